// File: logic/pdu_pkg.sv
package pdu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  hex_nibble_t;
    typedef logic [7:0]  print_tag_t;

    // Tag values double as the first character printed
    localparam print_tag_t TAG_CHECK = "c";
    localparam print_tag_t TAG_BP    = "b";

    // PC increment of one instruction
    localparam word_t PC_STEP = 32'd4;

    typedef enum logic [4:0] {
        S_IDLE,
        S_STEP_S, S_STEP_T, S_STEP_E, S_STEP_P, S_STEP_DONE,
        S_RUN_R, S_RUN_U, S_RUN_N, S_RUN,
        S_RST_S, S_RST_T, S_RST_DONE,
        S_CK_C, S_CK_K, S_CK_HEX, S_CK_DONE,
        S_ADD_A, S_ADD_D1, S_ADD_D2, S_ADD_DONE,
        S_SUB_U, S_SUB_B, S_SUB_DONE,
        S_BP_B, S_BP_HEX, S_BP_DONE,
        S_PRINT_CK, S_PRINT_BP
    } parser_state_t;

endpackage

// File: logic/print_req_if.sv
`timescale 1ns/1ps

interface print_req_if;

    logic                 push;
    pdu_pkg::word_t       word;
    pdu_pkg::print_tag_t  tag;
    logic                 full;

    modport source (
        output push,
        output word,
        output tag,
        input  full
    );

    // On the FIFO read side full acts as the pop strobe
    modport sink (
        input  push,
        input  word,
        input  tag,
        output full
    );

endinterface

// File: logic/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser #(
    parameter pdu_pkg::word_t PC_LOW  = 32'h2ff0,
    parameter pdu_pkg::word_t PC_HIGH = 32'h3fff
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ebreak,
    input  logic                din_vld,
    input  pdu_pkg::byte_t      din_data,
    input  pdu_pkg::word_t      current_pc,
    input  pdu_pkg::word_t      next_pc,
    input  logic                clk_busy,
    output logic                clk_req,
    output logic                cpu_rst,
    output pdu_pkg::word_t      check_addr,
    print_req_if.source         req
);

    pdu_pkg::parser_state_t state, state_next;
    pdu_pkg::word_t         bp_pc;
    pdu_pkg::word_t         acc;
    pdu_pkg::hex_nibble_t   digit;
    logic                   digit_vld;
    logic                   ebreak_q;
    logic                   ebreak_rise;
    logic                   run_stop;

    function automatic logic is_hex(pdu_pkg::byte_t c);
        return (c >= "0" && c <= "9") || (c >= "a" && c <= "f");
    endfunction

    function automatic pdu_pkg::hex_nibble_t hex_value(pdu_pkg::byte_t c);
        if (c <= "9") begin
            return pdu_pkg::hex_nibble_t'(c - "0");
        end
        return pdu_pkg::hex_nibble_t'(c - "a" + 8'd10);
    endfunction

    // Advance on the expected letter, anything else drops the command
    function automatic pdu_pkg::parser_state_t expect_char(
        pdu_pkg::byte_t         c,
        pdu_pkg::byte_t         want,
        pdu_pkg::parser_state_t on_match
    );
        return (c == want) ? on_match : pdu_pkg::S_IDLE;
    endfunction

    assign digit       = hex_value(din_data);
    assign digit_vld   = din_vld && is_hex(din_data);
    assign ebreak_rise = ebreak && !ebreak_q;

    // Only decide between periods, never in the middle of one
    assign run_stop = !clk_busy &&
                      (current_pc == bp_pc || current_pc < PC_LOW || current_pc > PC_HIGH);

    assign clk_req = (state == pdu_pkg::S_RUN) && !run_stop && !ebreak_rise;

    always_ff @(posedge clk) begin
        if (rst) begin
            ebreak_q <= 1'b0;
            state    <= pdu_pkg::S_IDLE;
            cpu_rst  <= 1'b0;
        end else begin
            ebreak_q <= ebreak;
            state    <= ebreak_rise ? pdu_pkg::S_IDLE : state_next;
            cpu_rst  <= (state == pdu_pkg::S_RST_DONE);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            pdu_pkg::S_IDLE: if (din_vld) begin
                case (din_data)
                    "s": state_next = pdu_pkg::S_STEP_S;
                    "r": state_next = pdu_pkg::S_RUN_R;
                    "c": state_next = pdu_pkg::S_CK_C;
                    "a": state_next = pdu_pkg::S_ADD_A;
                    "b": state_next = pdu_pkg::S_BP_B;
                    default: state_next = pdu_pkg::S_IDLE;
                endcase
            end

            // "s" opens both step and sub
            pdu_pkg::S_STEP_S: if (din_vld) begin
                case (din_data)
                    "t": state_next = pdu_pkg::S_STEP_T;
                    "u": state_next = pdu_pkg::S_SUB_U;
                    default: state_next = pdu_pkg::S_IDLE;
                endcase
            end
            pdu_pkg::S_STEP_T: if (din_vld) state_next = expect_char(din_data, "e", pdu_pkg::S_STEP_E);
            pdu_pkg::S_STEP_E: if (din_vld) state_next = expect_char(din_data, "p", pdu_pkg::S_STEP_P);
            pdu_pkg::S_STEP_P: if (din_vld) state_next = expect_char(din_data, ";", pdu_pkg::S_STEP_DONE);
            pdu_pkg::S_STEP_DONE: state_next = pdu_pkg::S_RUN;

            // "r" opens both run and rst
            pdu_pkg::S_RUN_R: if (din_vld) begin
                case (din_data)
                    "u": state_next = pdu_pkg::S_RUN_U;
                    "s": state_next = pdu_pkg::S_RST_S;
                    default: state_next = pdu_pkg::S_IDLE;
                endcase
            end
            pdu_pkg::S_RUN_U: if (din_vld) state_next = expect_char(din_data, "n", pdu_pkg::S_RUN_N);
            pdu_pkg::S_RUN_N: if (din_vld) state_next = expect_char(din_data, ";", pdu_pkg::S_RUN);
            pdu_pkg::S_RUN: if (run_stop) state_next = pdu_pkg::S_IDLE;

            pdu_pkg::S_RST_S: if (din_vld) state_next = expect_char(din_data, "t", pdu_pkg::S_RST_T);
            pdu_pkg::S_RST_T: if (din_vld) state_next = expect_char(din_data, ";", pdu_pkg::S_RST_DONE);
            pdu_pkg::S_RST_DONE: state_next = pdu_pkg::S_IDLE;

            pdu_pkg::S_CK_C: if (din_vld) state_next = expect_char(din_data, "k", pdu_pkg::S_CK_K);
            pdu_pkg::S_CK_K: if (din_vld) state_next = expect_char(din_data, " ", pdu_pkg::S_CK_HEX);
            pdu_pkg::S_CK_HEX: if (din_vld && !digit_vld) begin
                state_next = expect_char(din_data, ";", pdu_pkg::S_CK_DONE);
            end
            pdu_pkg::S_CK_DONE: state_next = pdu_pkg::S_PRINT_CK;

            pdu_pkg::S_ADD_A:  if (din_vld) state_next = expect_char(din_data, "d", pdu_pkg::S_ADD_D1);
            pdu_pkg::S_ADD_D1: if (din_vld) state_next = expect_char(din_data, "d", pdu_pkg::S_ADD_D2);
            pdu_pkg::S_ADD_D2: if (din_vld) state_next = expect_char(din_data, ";", pdu_pkg::S_ADD_DONE);
            pdu_pkg::S_ADD_DONE: state_next = pdu_pkg::S_PRINT_CK;

            pdu_pkg::S_SUB_U: if (din_vld) state_next = expect_char(din_data, "b", pdu_pkg::S_SUB_B);
            pdu_pkg::S_SUB_B: if (din_vld) state_next = expect_char(din_data, ";", pdu_pkg::S_SUB_DONE);
            pdu_pkg::S_SUB_DONE: state_next = pdu_pkg::S_PRINT_CK;

            pdu_pkg::S_BP_B: if (din_vld) state_next = expect_char(din_data, "p", pdu_pkg::S_BP_HEX);
            // Spaces between bp and the digits are skipped
            pdu_pkg::S_BP_HEX: if (din_vld && !digit_vld && din_data != " ") begin
                state_next = expect_char(din_data, ";", pdu_pkg::S_BP_DONE);
            end
            pdu_pkg::S_BP_DONE: state_next = pdu_pkg::S_PRINT_BP;

            pdu_pkg::S_PRINT_CK,
            pdu_pkg::S_PRINT_BP: if (!req.full) state_next = pdu_pkg::S_IDLE;

            default: state_next = pdu_pkg::S_IDLE;
        endcase
    end

    // Hex accumulator, restarted with each c or b command
    always_ff @(posedge clk) begin
        if (state == pdu_pkg::S_IDLE && din_vld && (din_data == "c" || din_data == "b")) begin
            acc <= '0;
        end else if (digit_vld &&
                     (state == pdu_pkg::S_CK_HEX || state == pdu_pkg::S_BP_HEX)) begin
            acc <= {acc[27:0], digit};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            check_addr <= '0;
            bp_pc      <= '0;
        end else begin
            case (state)
                pdu_pkg::S_CK_DONE:   check_addr <= acc;
                pdu_pkg::S_ADD_DONE:  check_addr <= check_addr + 32'd1;
                pdu_pkg::S_SUB_DONE:  check_addr <= check_addr - 32'd1;
                pdu_pkg::S_STEP_DONE: bp_pc <= next_pc;
                pdu_pkg::S_BP_HEX: if (digit_vld) bp_pc <= {acc[27:0], digit};
                default: ;
            endcase
        end
    end

    // Request waits in the print state while the FIFO is full
    assign req.push = (state == pdu_pkg::S_PRINT_CK || state == pdu_pkg::S_PRINT_BP) && !req.full;
    assign req.word = (state == pdu_pkg::S_PRINT_BP) ? bp_pc : check_addr;
    assign req.tag  = (state == pdu_pkg::S_PRINT_BP) ? pdu_pkg::TAG_BP : pdu_pkg::TAG_CHECK;

endmodule

// File: logic/print_fifo.sv
`timescale 1ns/1ps

module print_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    print_req_if.sink   wr,
    print_req_if.source rd
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pdu_pkg::word_t      word_mem [FIFO_DEPTH];
    pdu_pkg::print_tag_t tag_mem  [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_write;
    logic                do_read;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr.full  = (count == CNT_W'(FIFO_DEPTH));
    assign do_write = wr.push && !wr.full;
    assign do_read  = rd.full && (count != '0);

    // Head entry is always presented on the read side
    assign rd.push = (count != '0);
    assign rd.word = word_mem[rd_ptr];
    assign rd.tag  = tag_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            word_mem[wr_ptr] <= wr.word;
            tag_mem[wr_ptr]  <= wr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= next_ptr(wr_ptr);
            if (do_read) rd_ptr <= next_ptr(rd_ptr);
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/hex_printer.sv
`timescale 1ns/1ps

module hex_printer (
    input  logic            clk,
    input  logic            rst,
    print_req_if.sink       req,
    output logic            dout_vld,
    output pdu_pkg::byte_t  dout_data
);

    // Character slots within one line
    localparam logic [3:0] CHAR_TAG = 4'd0;
    localparam logic [3:0] CHAR_NL  = 4'd9;

    logic                        busy;
    logic [3:0]                  char_cnt;
    pdu_pkg::hex_nibble_t [7:0]  digits;
    pdu_pkg::print_tag_t         tag_q;
    logic                        pop;

    function automatic pdu_pkg::byte_t to_ascii(pdu_pkg::hex_nibble_t n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};
        end
        return 8'h57 + {4'h0, n};
    endfunction

    assign pop      = !busy && req.push;
    assign req.full = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            char_cnt <= '0;
        end else if (pop) begin
            busy     <= 1'b1;
            char_cnt <= CHAR_TAG;
        end else if (busy) begin
            if (char_cnt == CHAR_NL) begin
                busy <= 1'b0;
            end else begin
                char_cnt <= char_cnt + 4'd1;
            end
        end
    end

    // Most significant digit sits at the top and shifts out first
    always_ff @(posedge clk) begin
        if (pop) begin
            digits <= req.word;
            tag_q  <= req.tag;
        end else if (busy && char_cnt != CHAR_TAG && char_cnt != CHAR_NL) begin
            digits <= {digits[6:0], 4'h0};
        end
    end

    assign dout_vld = busy;

    always_comb begin
        case (char_cnt)
            CHAR_TAG: dout_data = tag_q;
            CHAR_NL:  dout_data = "\n";
            default:  dout_data = to_ascii(digits[7]);
        endcase
    end

endmodule

// File: logic/cpu_clock_gen.sv
`timescale 1ns/1ps

module cpu_clock_gen #(
    parameter int CLK_HALF = 50
) (
    input  logic clk,
    input  logic rst,
    input  logic clk_req,
    output logic clk_busy,
    output logic cpu_clk
);

    localparam int PERIOD = 2 * CLK_HALF;
    localparam int CNT_W  = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PERIOD - 1);
    localparam logic [CNT_W-1:0] HIGH_END = CNT_W'(CLK_HALF - 1);

    logic             active;
    logic [CNT_W-1:0] phase_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            phase_cnt <= '0;
            cpu_clk   <= 1'b0;
        end else if (!active) begin
            if (clk_req) begin
                active    <= 1'b1;
                phase_cnt <= '0;
                cpu_clk   <= 1'b1;
            end
        end else if (phase_cnt == LAST_CNT) begin
            active    <= 1'b0;
            phase_cnt <= '0;
            cpu_clk   <= 1'b0;
        end else begin
            // High through the first CLK_HALF cycles of the period
            phase_cnt <= phase_cnt + 1'b1;
            cpu_clk   <= (phase_cnt < HIGH_END);
        end
    end

    assign clk_busy = active;

endmodule

// File: logic/pdu_top.sv
`timescale 1ns/1ps

module pdu_top #(
    parameter int             CLK_HALF   = 50,
    parameter pdu_pkg::word_t PC_LOW     = 32'h2ff0,
    parameter pdu_pkg::word_t PC_HIGH    = 32'h3fff,
    parameter int             FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ebreak,
    input  logic            din_vld,
    input  pdu_pkg::byte_t  din_data,
    output logic            dout_vld,
    output pdu_pkg::byte_t  dout_data,
    output pdu_pkg::word_t  check_addr,
    output logic            cpu_rst,
    output logic            cpu_clk,
    input  pdu_pkg::word_t  current_pc,
    input  pdu_pkg::word_t  next_pc
);

    logic clk_req;
    logic clk_busy;

    print_req_if req_in ();
    print_req_if req_out ();

    cmd_parser #(
        .PC_LOW  (PC_LOW),
        .PC_HIGH (PC_HIGH)
    ) u_parser (
        .clk        (clk),
        .rst        (rst),
        .ebreak     (ebreak),
        .din_vld    (din_vld),
        .din_data   (din_data),
        .current_pc (current_pc),
        .next_pc    (next_pc),
        .clk_busy   (clk_busy),
        .clk_req    (clk_req),
        .cpu_rst    (cpu_rst),
        .check_addr (check_addr),
        .req        (req_in)
    );

    print_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (req_in),
        .rd  (req_out)
    );

    hex_printer u_printer (
        .clk       (clk),
        .rst       (rst),
        .req       (req_out),
        .dout_vld  (dout_vld),
        .dout_data (dout_data)
    );

    cpu_clock_gen #(
        .CLK_HALF (CLK_HALF)
    ) u_clk_gen (
        .clk      (clk),
        .rst      (rst),
        .clk_req  (clk_req),
        .clk_busy (clk_busy),
        .cpu_clk  (cpu_clk)
    );

endmodule

// File: test/pdu_tb_cases.svh
// Each row holds name, command, expected output with \n for newline, expected check_addr,
// fewest and most cpu_clk rises, cpu_rst pulses, cycles from command to ebreak (0 for none)
task automatic load_cases();
    add_case("ck_set",      "ck 1f;",   "c0000001f\\n", 32'h1f, 0,    0,    0, 0);
    add_case("add_up",      "add;",     "c00000020\\n", 32'h20, 0,    0,    0, 0);
    add_case("sub_back",    "sub;",     "c0000001f\\n", 32'h1f, 0,    0,    0, 0);
    add_case("sub_below",   "sub;",     "c0000001e\\n", 32'h1e, 0,    0,    0, 0);
    add_case("bp_set",      "bp 3010;", "b00003010\\n", 32'h1e, 0,    0,    0, 0);
    add_case("run_to_bp",   "run;",     "",             32'h1e, 4,    4,    0, 0);
    add_case("step_one",    "step;",    "",             32'h1e, 1,    1,    0, 0);
    add_case("cpu_reset",   "rst;",     "",             32'h1e, 0,    0,    1, 0);
    add_case("ck_broken",   "ckx",      "",             32'h1e, 0,    0,    0, 0);
    add_case("stop_broken", "stop;",    "",             32'h1e, 0,    0,    0, 0);
    add_case("ck_after",    "ck 2a;",   "c0000002a\\n", 32'h2a, 0,    0,    0, 0);
    add_case("bp_outside",  "bp 5000;", "b00005000\\n", 32'h2a, 0,    0,    0, 0);
    add_case("run_window",  "run;",     "",             32'h2a, 1024, 1024, 0, 0);
    add_case("reset_again", "rst;",     "",             32'h2a, 0,    0,    1, 0);
    add_case("run_ebreak",  "run;",     "",             32'h2a, 8,    12,   0, 950);
    add_case("add_after",   "add;",     "c0000002b\\n", 32'h2b, 0,    0,    0, 0);
endtask

// File: test/pdu_tb.sv
`timescale 1ns/1ps

module pdu_tb;

    localparam int CLK_HALF = 50;

    typedef struct {
        string          name;
        string          cmd;
        string          out;
        pdu_pkg::word_t addr;
        int             min_rises;
        int             max_rises;
        int             rsts;
        int             ebreak_at;
    } case_t;

    logic           clk = 1'b0;
    logic           rst = 1'b1;
    logic           ebreak = 1'b0;
    logic           din_vld = 1'b0;
    pdu_pkg::byte_t din_data = '0;
    logic           dout_vld;
    pdu_pkg::byte_t dout_data;
    pdu_pkg::word_t check_addr;
    logic           cpu_rst;
    logic           cpu_clk;
    logic           cpu_clk_q = 1'b0;
    pdu_pkg::word_t current_pc = 32'h3000;
    pdu_pkg::word_t next_pc;

    case_t          cases[$];
    pdu_pkg::byte_t out_bytes[$];
    int             rise_count = 0;
    int             rst_count = 0;
    int             passed = 0;
    int             failed = 0;
    int unsigned    cycles = 0;
    int unsigned    cycle_limit = 0;

    pdu_top #(.CLK_HALF(CLK_HALF)) DUT (.*);

    always #4 clk = ~clk;

    assign next_pc = current_pc + pdu_pkg::PC_STEP;

    // CPU model and output capture run on the falling edge
    always @(negedge clk) begin
        cpu_clk_q <= cpu_clk;
        if (rst || cpu_rst) begin
            current_pc <= 32'h3000;
        end else if (cpu_clk && !cpu_clk_q) begin
            current_pc <= current_pc + pdu_pkg::PC_STEP;
            rise_count <= rise_count + 1;
        end
        if (cpu_rst) begin
            rst_count <= rst_count + 1;
        end
        if (dout_vld) begin
            out_bytes.push_back(dout_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles with the parser in %s",
                     cycles, DUT.u_parser.state.name());
            $display("TESTS FAILED");
            $finish;
        end
    end

    `include "pdu_tb_cases.svh"

    task automatic add_case(string name, string cmd, string out, pdu_pkg::word_t addr,
                            int min_rises, int max_rises, int rsts, int ebreak_at);
        cases.push_back(case_t'{name, cmd, out, addr, min_rises, max_rises, rsts, ebreak_at});
    endtask

    task automatic send_byte(pdu_pkg::byte_t b);
        @(negedge clk);
        din_vld  = 1'b1;
        din_data = b;
        @(negedge clk);
        din_vld = 1'b0;
        repeat ($urandom_range(10, 3)) @(negedge clk);
    endtask

    // Wait until the parser is idle with no CPU period and nothing queued or printing
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            if (DUT.u_parser.state == pdu_pkg::S_IDLE && !DUT.u_clk_gen.clk_busy &&
                DUT.u_fifo.count == 0 && !dout_vld && !cpu_rst) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic check_equal(string test, string expected, string actual);
        if (expected == actual) begin
            $display("%-12s pass", test);
            passed++;
        end else begin
            $display("Mismatch %s: expected %s, actual %s", test, expected, actual);
            failed++;
        end
    endtask

    task automatic run_case(case_t c);
        int    out_start;
        int    rise_start;
        int    rst_start;
        int    rises;
        string rise_txt;
        string got;
        out_start  = out_bytes.size();
        rise_start = rise_count;
        rst_start  = rst_count;
        got        = "";
        for (int k = 0; k < c.cmd.len(); k++) begin
            send_byte(c.cmd[k]);
        end
        if (c.ebreak_at > 0) begin
            repeat (c.ebreak_at) @(negedge clk);
            ebreak = 1'b1;
            repeat (2) @(negedge clk);
            ebreak = 1'b0;
        end
        wait_quiet();
        for (int k = out_start; k < out_bytes.size(); k++) begin
            if (out_bytes[k] == 8'h0a) begin
                got = {got, "\\n"};
            end else begin
                got = $sformatf("%s%c", got, out_bytes[k]);
            end
        end
        // A rise count inside the allowed range shows as the range itself
        rises    = rise_count - rise_start;
        rise_txt = (c.min_rises == c.max_rises) ?
                   $sformatf("%0d", c.min_rises) :
                   $sformatf("%0d..%0d", c.min_rises, c.max_rises);
        check_equal(c.name,
                    $sformatf("'%s' addr=%08h rises=%s rst=%0d", c.out, c.addr, rise_txt, c.rsts),
                    $sformatf("'%s' addr=%08h rises=%s rst=%0d", got, check_addr,
                              (rises >= c.min_rises && rises <= c.max_rises) ? rise_txt
                                                                : $sformatf("%0d", rises),
                              rst_count - rst_start));
    endtask

    initial begin
        void'($urandom(32'he591));
        load_cases();
        foreach (cases[i]) begin
            cycle_limit += cases[i].cmd.len() * 10 + 200 * 2 * CLK_HALF;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        foreach (cases[i]) begin
            run_case(cases[i]);
        end
        $display("%0d tests, %0d passed, %0d failed", cases.size(), passed, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+test
logic/pdu_pkg.sv
logic/print_req_if.sv
logic/cmd_parser.sv
logic/print_fifo.sv
logic/hex_printer.sv
logic/cpu_clock_gen.sv
logic/pdu_top.sv
test/pdu_tb.sv
